// ==== src/uart_consts.svh ====
// UART peripheral constants
// Bus field widths, register map and reset values shared by the RTL
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// Serial and bus widths
`define UART_DATA_W          8
`define MEM_ADDR_W           32
`define MEM_DATA_W           32

// Address bits compared with the peripheral base
`define UART_BASE_FIELD_MSB  31
`define UART_BASE_FIELD_LSB  24

// Register byte offsets in addr[3:0]
`define UART_REG_TX          4'h0
`define UART_REG_STATUS      4'h4
`define UART_REG_RX          4'h8
`define UART_REG_BAUD        4'hC

// Read value when no received byte waits
`define UART_RX_EMPTY_FLAG   32'hFFFF_FF00
`define UART_PRESCALE_RST    16'd1

`endif

// ==== src/mem_bus_pkg.sv ====
// Processor memory bus types
// Packed request and response words exchanged with the address decoder
`default_nettype none
`include "uart_consts.svh"

package mem_bus_pkg;

    // --------------------
    // Request, 69 bits
    // --------------------
    // Write data sits in the top bits, address in the bottom bits
    typedef struct packed {
        logic [`MEM_DATA_W-1:0]   wdata;
        logic [`MEM_DATA_W/8-1:0] wstrb;
        logic                     valid;
        logic [`MEM_ADDR_W-1:0]   addr;
    } mem_req_t;

    // --------------------
    // Response, 33 bits
    // --------------------
    typedef struct packed {
        logic                   ready;
        logic [`MEM_DATA_W-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

// ==== src/uart_pkg.sv ====
// UART register types
// Register select decoded from the bus offset and the status word layout
`default_nettype none

package uart_pkg;

    // One entry per byte-aligned register
    typedef enum logic [1:0] {
        reg_tx,
        reg_status,
        reg_rx,
        reg_baud
    } uart_reg_e;

    // Status read word, listed from bit 3 down to bit 0
    // Overrun and frame error are sticky until a status read
    typedef struct packed {
        logic frame_err;
        logic overrun;
        logic rx_busy;
        logic tx_busy;
    } uart_status_t;

endpackage

`default_nettype wire

// ==== src/uart_byte_if.sv ====
// Byte link between the register block and one serial engine
// Carries a byte with its valid/ready handshake and the engine busy level
`timescale 1ns/1ps
`default_nettype none
`include "uart_consts.svh"

interface uart_byte_if;

    // Handshake lines are nets: on the transmit link the controller
    // sources data and valid, on the receive link it sources ready
    wire [`UART_DATA_W-1:0] data;
    wire                    valid;
    wire                    ready;
    wire                    busy;

    // Register block side
    modport ctrl (inout data, inout valid, inout ready, input busy);

    // Serializer or deserializer side
    modport engine (inout data, inout valid, inout ready, output busy);

endinterface

`default_nettype wire

// ==== src/mem_bus_unpack.sv ====
// Memory bus unpacker
// Breaks out the request fields, turns the valid level into a one-cycle
// request strobe and packs the response word
`timescale 1ns/1ps
`default_nettype none
`include "uart_consts.svh"

module mem_bus_unpack (
    input  wire                      clk,
    input  wire                      rst,
    input  mem_bus_pkg::mem_req_t    mem_packed_fwd,
    output mem_bus_pkg::mem_rsp_t    mem_packed_ret,
    output logic                     req_strobe,
    output logic [`MEM_ADDR_W-1:0]   addr,
    output logic [`MEM_DATA_W-1:0]   wdata,
    output logic [`MEM_DATA_W/8-1:0] wstrb,
    input  wire                      rsp_ready,
    input  wire  [`MEM_DATA_W-1:0]   rsp_rdata
);

    logic valid_q;

    // Previous valid for edge detection
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mem_packed_fwd.valid;
        end
    end

    // New request on the first cycle valid is seen high
    assign req_strobe = mem_packed_fwd.valid && !valid_q;

    assign addr  = mem_packed_fwd.addr;
    assign wdata = mem_packed_fwd.wdata;
    assign wstrb = mem_packed_fwd.wstrb;

    assign mem_packed_ret.ready = rsp_ready;
    assign mem_packed_ret.rdata = rsp_rdata;

    // One strobe per request, never back to back
    a_strobe_single : assert property (@(posedge clk) disable iff (rst)
        req_strobe |=> !req_strobe);

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
// UART transmitter
// Sends 8N1 frames, start bit, data LSB first, then stop bit,
// with each bit lasting prescale x 8 clocks
`timescale 1ns/1ps
`default_nettype none
`include "uart_consts.svh"

module uart_tx (
    input  wire          clk,
    input  wire          rst,
    uart_byte_if.engine  tx,
    input  wire   [15:0] prescale,
    output logic         txd
);

    // Data bits plus the stop bit, shifted out LSB first
    logic [`UART_DATA_W:0] shreg;
    logic [3:0]            bit_cnt;
    logic [18:0]           timer;
    logic                  busy_q;

    // Clocks per bit minus one
    wire [18:0] bit_len = {prescale, 3'b000} - 19'd1;

    // Ready low from acceptance until the stop bit ends
    assign tx.ready = !busy_q;
    assign tx.busy  = busy_q;

    // --------------------
    // Frame sequencer
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            txd     <= 1'b1;
            busy_q  <= 1'b0;
            bit_cnt <= '0;
            timer   <= '0;
        end else if (!busy_q) begin
            // Start bit goes out on the cycle after acceptance
            if (tx.valid) begin
                txd     <= 1'b0;
                shreg   <= {1'b1, tx.data};
                bit_cnt <= 4'(`UART_DATA_W + 1);
                timer   <= bit_len;
                busy_q  <= 1'b1;
            end
        end else if (timer != '0) begin
            timer <= timer - 19'd1;
        end else if (bit_cnt != '0) begin
            // Next data bit or the stop bit
            txd     <= shreg[0];
            shreg   <= shreg >> 1;
            bit_cnt <= bit_cnt - 4'd1;
            timer   <= bit_len;
        end else begin
            // Stop bit has run its full length
            busy_q <= 1'b0;
        end
    end

    // Controller only offers a byte while the engine is free
    a_tx_valid_ready : assert property (@(posedge clk) disable iff (rst)
        tx.valid |-> tx.ready);

endmodule

`default_nettype wire

// ==== src/uart_rx.sv ====
// UART receiver
// Two-flop input synchronizer, start bit confirmed at half bit, data
// sampled at bit middles, byte held until the controller takes it
`timescale 1ns/1ps
`default_nettype none
`include "uart_consts.svh"

module uart_rx (
    input  wire          clk,
    input  wire          rst,
    uart_byte_if.engine  rx,
    input  wire   [15:0] prescale,
    input  wire          rxd,
    output logic         overrun,
    output logic         frame_err
);

    localparam logic [3:0] LAST_DATA = 4'(`UART_DATA_W);

    logic                    rxd_meta;
    logic                    rxd_sync;
    logic [`UART_DATA_W-1:0] shreg;
    logic [`UART_DATA_W-1:0] data_q;
    logic                    valid_q;
    logic                    busy_q;
    // 0 is the start bit, 1..8 data, 9 the stop bit
    logic [3:0]              bit_cnt;
    logic [18:0]             timer;

    wire [18:0] bit_len  = {prescale, 3'b000} - 19'd1;
    wire [18:0] half_len = {1'b0, prescale, 2'b00} - 19'd1;

    assign rx.data  = data_q;
    assign rx.valid = valid_q;
    assign rx.busy  = busy_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_meta  <= 1'b1;
            rxd_sync  <= 1'b1;
            valid_q   <= 1'b0;
            busy_q    <= 1'b0;
            bit_cnt   <= '0;
            timer     <= '0;
            overrun   <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            rxd_meta  <= rxd;
            rxd_sync  <= rxd_meta;
            overrun   <= 1'b0;
            frame_err <= 1'b0;

            // Byte taken by the controller
            if (valid_q && rx.ready) begin
                valid_q <= 1'b0;
            end

            if (!busy_q) begin
                // Falling edge may be a start bit
                if (!rxd_sync) begin
                    busy_q  <= 1'b1;
                    bit_cnt <= '0;
                    timer   <= half_len;
                end
            end else if (timer != '0) begin
                timer <= timer - 19'd1;
            end else if (bit_cnt == '0) begin
                // Middle of the start bit, a high line was a glitch
                if (rxd_sync) begin
                    busy_q <= 1'b0;
                end else begin
                    bit_cnt <= 4'd1;
                    timer   <= bit_len;
                end
            end else if (bit_cnt <= LAST_DATA) begin
                shreg   <= {rxd_sync, shreg[`UART_DATA_W-1:1]};
                bit_cnt <= bit_cnt + 4'd1;
                timer   <= bit_len;
            end else begin
                // Middle of the stop bit
                busy_q <= 1'b0;
                if (!rxd_sync) begin
                    frame_err <= 1'b1;
                end else if (valid_q && !rx.ready) begin
                    // Old byte kept, new one dropped
                    overrun <= 1'b1;
                end else begin
                    data_q  <= shreg;
                    valid_q <= 1'b1;
                end
            end
        end
    end

    // A stop bit ends in exactly one outcome
    a_rx_err_excl : assert property (@(posedge clk) disable iff (rst)
        !(overrun && frame_err));

endmodule

`default_nettype wire

// ==== src/uart_regs.sv ====
// UART register block
// Decodes bus accesses to the TX, status, RX and baud registers, holds
// the prescale and sticky error flags, and stalls TX writes while busy
`timescale 1ns/1ps
`default_nettype none
`include "uart_consts.svh"

module uart_regs #(
    parameter logic [7:0] BASE_ADDR = 8'h00
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      req_strobe,
    input  wire  [`MEM_ADDR_W-1:0]   addr,
    input  wire  [`MEM_DATA_W-1:0]   wdata,
    input  wire  [`MEM_DATA_W/8-1:0] wstrb,
    output logic                     rsp_ready,
    output logic [`MEM_DATA_W-1:0]   rsp_rdata,
    uart_byte_if.ctrl                tx,
    uart_byte_if.ctrl                rx,
    input  wire                      overrun,
    input  wire                      frame_err,
    output logic [15:0]              prescale
);

    import uart_pkg::*;

    logic [`UART_DATA_W-1:0] tx_data_q;
    logic                    tx_valid_q;
    logic                    rx_ready_q;
    logic                    stalled;
    logic                    overrun_q;
    logic                    frame_err_q;
    logic                    hit;
    logic                    sel_ok;
    logic                    is_write;
    logic                    tx_free;
    uart_reg_e               sel;
    uart_status_t            status;

    assign tx.data  = tx_data_q;
    assign tx.valid = tx_valid_q;
    assign rx.ready = rx_ready_q;

    // --------------------
    // Access decode
    // --------------------
    assign hit = req_strobe &&
        (addr[`UART_BASE_FIELD_MSB:`UART_BASE_FIELD_LSB] == BASE_ADDR);
    assign is_write = |wstrb;
    // Not free in the cycle a byte is being handed over
    assign tx_free = tx.ready && !tx_valid_q;

    always_comb begin
        sel_ok = 1'b1;
        case (addr[3:0])
            `UART_REG_TX:     sel = reg_tx;
            `UART_REG_STATUS: sel = reg_status;
            `UART_REG_RX:     sel = reg_rx;
            `UART_REG_BAUD:   sel = reg_baud;
            default: begin
                sel    = reg_tx;
                sel_ok = 1'b0;
            end
        endcase
    end

    assign status = '{frame_err: frame_err_q, overrun: overrun_q,
                      rx_busy: rx.busy, tx_busy: tx.busy};

    // --------------------
    // Register actions
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_ready   <= 1'b0;
            rsp_rdata   <= '0;
            tx_valid_q  <= 1'b0;
            rx_ready_q  <= 1'b0;
            stalled     <= 1'b0;
            overrun_q   <= 1'b0;
            frame_err_q <= 1'b0;
            prescale    <= `UART_PRESCALE_RST;
        end else begin
            // Single-cycle pulses by default
            rsp_ready  <= 1'b0;
            rsp_rdata  <= '0;
            tx_valid_q <= 1'b0;
            rx_ready_q <= 1'b0;

            if (stalled) begin
                // Held TX write, launch once the transmitter frees up
                if (tx_free) begin
                    tx_valid_q <= 1'b1;
                    rsp_ready  <= 1'b1;
                    stalled    <= 1'b0;
                end
            end else if (hit && sel_ok) begin
                case (sel)
                    reg_tx: begin
                        // Only the low byte lane starts a frame
                        if (is_write && wstrb[0]) begin
                            tx_data_q <= wdata[`UART_DATA_W-1:0];
                            if (tx_free) begin
                                tx_valid_q <= 1'b1;
                                rsp_ready  <= 1'b1;
                            end else begin
                                stalled <= 1'b1;
                            end
                        end
                    end
                    reg_status: begin
                        if (!is_write) begin
                            rsp_rdata <= {{(`MEM_DATA_W - $bits(uart_status_t)){1'b0}}, status};
                            overrun_q   <= 1'b0;
                            frame_err_q <= 1'b0;
                            rsp_ready   <= 1'b1;
                        end
                    end
                    reg_rx: begin
                        if (!is_write) begin
                            if (rx.valid) begin
                                rsp_rdata  <= {{(`MEM_DATA_W - `UART_DATA_W){1'b0}}, rx.data};
                                rx_ready_q <= 1'b1;
                            end else begin
                                rsp_rdata <= `UART_RX_EMPTY_FLAG;
                            end
                            rsp_ready <= 1'b1;
                        end
                    end
                    reg_baud: begin
                        if (is_write) begin
                            if (wstrb[0]) prescale[7:0]  <= wdata[7:0];
                            if (wstrb[1]) prescale[15:8] <= wdata[15:8];
                            rsp_ready <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end

            // New errors win over a clear in the same cycle
            if (overrun)   overrun_q   <= 1'b1;
            if (frame_err) frame_err_q <= 1'b1;
        end
    end

    // The processor sees exactly one ready cycle per access
    a_rsp_pulse : assert property (@(posedge clk) disable iff (rst)
        rsp_ready |=> !rsp_ready);

endmodule

`default_nettype wire

// ==== src/uart_mmio.sv ====
// Memory-mapped UART peripheral
// Joins the bus unpacker, register block and the two serial engines,
// and brings the receive-valid level out as an interrupt
`timescale 1ns/1ps
`default_nettype none
`include "uart_consts.svh"

module uart_mmio #(
    parameter logic [7:0] BASE_ADDR = 8'h00
) (
    input  wire                                     clk,
    input  wire                                     rst,
    input  wire                                     rxd,
    output logic                                    txd,
    output logic                                    irq_rx_valid,
    input  wire  [$bits(mem_bus_pkg::mem_req_t)-1:0] mem_packed_fwd,
    output logic [$bits(mem_bus_pkg::mem_rsp_t)-1:0] mem_packed_ret
);

    logic                     req_strobe;
    logic [`MEM_ADDR_W-1:0]   addr;
    logic [`MEM_DATA_W-1:0]   wdata;
    logic [`MEM_DATA_W/8-1:0] wstrb;
    logic                     rsp_ready;
    logic [`MEM_DATA_W-1:0]   rsp_rdata;
    logic [15:0]              prescale;
    logic                     overrun;
    logic                     frame_err;

    // One link per direction
    uart_byte_if tx_if ();
    uart_byte_if rx_if ();

    // Interrupt follows the waiting receive byte
    assign irq_rx_valid = rx_if.valid;

    mem_bus_unpack u_unpack (
        .clk            (clk),
        .rst            (rst),
        .mem_packed_fwd (mem_packed_fwd),
        .mem_packed_ret (mem_packed_ret),
        .req_strobe     (req_strobe),
        .addr           (addr),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .rsp_ready      (rsp_ready),
        .rsp_rdata      (rsp_rdata)
    );

    uart_regs #(
        .BASE_ADDR (BASE_ADDR)
    ) u_regs (
        .clk        (clk),
        .rst        (rst),
        .req_strobe (req_strobe),
        .addr       (addr),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .rsp_ready  (rsp_ready),
        .rsp_rdata  (rsp_rdata),
        .tx         (tx_if.ctrl),
        .rx         (rx_if.ctrl),
        .overrun    (overrun),
        .frame_err  (frame_err),
        .prescale   (prescale)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst      (rst),
        .tx       (tx_if.engine),
        .prescale (prescale),
        .txd      (txd)
    );

    uart_rx u_rx (
        .clk       (clk),
        .rst       (rst),
        .rx        (rx_if.engine),
        .prescale  (prescale),
        .rxd       (rxd),
        .overrun   (overrun),
        .frame_err (frame_err)
    );

endmodule

`default_nettype wire

// ==== verif/uart_mmio_tb.sv ====
// Testbench for the memory-mapped UART
// Bus tasks, serial driver and txd monitor, loopback mux, LFSR payloads,
// assertions for checking and a watchdog
`timescale 1ns/1ps
`default_nettype none
`include "uart_consts.svh"

module uart_mmio_tb;

    import mem_bus_pkg::*;

    localparam logic [7:0] BASE_ADDR   = 8'h02;
    localparam int         PRESCALE    = 2;
    localparam int         BIT_CYC     = PRESCALE * 8;
    localparam int         FRAME_CYC   = 10 * BIT_CYC;
    localparam int         BUS_WAIT    = 20;
    localparam int         STALL_WAIT  = FRAME_CYC + 40;
    // 4 + 2 + 1 + 2 + 1 frames, about 20 bus accesses
    localparam int         NUM_FRAMES  = 10;
    localparam int         NUM_ACCESS  = 20;
    localparam int         TIMEOUT_CYC = NUM_FRAMES * FRAME_CYC + NUM_ACCESS * 200;

    logic        clk;
    logic        rst;
    mem_req_t    req;
    mem_rsp_t    rsp;
    wire         txd;
    wire         irq_rx_valid;
    wire         rxd;
    logic        loop_sel;
    logic        drv_line;
    logic        frame_phase;
    logic [31:0] lfsr_state;
    int          checks;
    int          errors;

    // Receive line comes from the transmitter or the serial driver
    assign rxd = loop_sel ? txd : drv_line;

    uart_mmio #(
        .BASE_ADDR (BASE_ADDR)
    ) DUT (
        .clk            (clk),
        .rst            (rst),
        .rxd            (rxd),
        .txd            (txd),
        .irq_rx_valid   (irq_rx_valid),
        .mem_packed_fwd (req),
        .mem_packed_ret (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------
    // Protocol assertions
    // --------------------
    // Ready only answers a pending request, and only for one cycle
    ready_needs_req : assert property (@(posedge clk) disable iff (rst)
        rsp.ready |-> req.valid)
        else begin
            $display("Bus ready seen with no request pending");
            errors++;
        end

    ready_single : assert property (@(posedge clk) disable iff (rst)
        rsp.ready |=> !rsp.ready)
        else begin
            $display("Bus ready held longer than one cycle");
            errors++;
        end

    // A byte with a bad stop bit never raises the interrupt
    irq_quiet_on_ferr : assert property (@(posedge clk) disable iff (rst)
        frame_phase |-> !irq_rx_valid)
        else begin
            $display("Interrupt raised by a frame with a low stop bit");
            errors++;
        end

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
    endfunction

    // One LFSR step per payload bit
    task automatic next_byte(output logic [7:0] b);
        int i;
        for (i = 0; i < 8; i++) begin
            b[i] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic logic [31:0] reg_addr(input logic [3:0] off);
        return {BASE_ADDR, 20'h0_0000, off};
    endfunction

    // Frame error in bit 3, overrun in bit 2, both busy bits idle
    function automatic logic [31:0] status_word(input logic ovr, input logic ferr);
        return {28'h0, ferr, ovr, 2'b00};
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        value_ok : assert (act === exp)
            else begin
                $display("Error %s: expected %h, actual %h", name, exp, act);
                errors++;
            end
    endtask

    task automatic check_true(input string name, input logic cond, input string what);
        checks++;
        cond_ok : assert (cond === 1'b1)
            else begin
                $display("%s: %s", name, what);
                errors++;
            end
    endtask

    // Raise valid, wait for the ready pulse, drop valid
    task automatic bus_access(input logic [31:0] a, input logic [31:0] d,
                              input logic [3:0] strb, input int max_wait,
                              output logic [31:0] rdata, output logic got);
        int n;
        got   = 1'b0;
        rdata = '0;
        n     = 0;
        @(posedge clk);
        req <= '{wdata: d, wstrb: strb, valid: 1'b1, addr: a};
        while (!got && n < max_wait) begin
            @(posedge clk);
            n++;
            if (rsp.ready) begin
                got   = 1'b1;
                rdata = rsp.rdata;
            end
        end
        req.valid <= 1'b0;
    endtask

    task automatic reg_write(input string name, input logic [3:0] off,
                             input logic [31:0] d, input logic [3:0] strb);
        logic [31:0] unused;
        logic        got;
        bus_access(reg_addr(off), d, strb, STALL_WAIT, unused, got);
        check_true(name, got, "write got no bus ready");
    endtask

    task automatic check_read(input string name, input logic [3:0] off,
                              input logic [31:0] exp);
        logic [31:0] rd;
        logic        got;
        bus_access(reg_addr(off), 32'h0, 4'b0000, BUS_WAIT, rd, got);
        check_true(name, got, "read got no bus ready");
        check_val(name, exp, rd);
    endtask

    // Samples each bit at its middle and on its last cycle
    task automatic capture_frame(output logic [7:0] data, output logic shape_ok);
        logic [9:0] mid;
        logic [9:0] late;
        int         c;
        mid  = '0;
        late = '0;
        while (txd !== 1'b0) @(posedge clk);
        for (c = 1; c < FRAME_CYC; c++) begin
            @(posedge clk);
            if (c % BIT_CYC == BIT_CYC / 2) mid[c / BIT_CYC] = txd;
            if (c % BIT_CYC == BIT_CYC - 1) late[c / BIT_CYC] = txd;
        end
        data     = mid[8:1];
        shape_ok = !mid[0] && mid[9] && (late == mid);
    endtask

    // Frame on the driver line, then one idle bit time
    task automatic drive_serial(input logic [7:0] data, input logic stop);
        logic [9:0] frame;
        int         i;
        frame = {stop, data, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            drv_line <= frame[i];
            repeat (BIT_CYC - 1) @(posedge clk);
        end
        @(posedge clk);
        drv_line <= 1'b1;
        repeat (BIT_CYC - 1) @(posedge clk);
    endtask

    task automatic send_one(input string name, input logic [7:0] b);
        logic [7:0] cap;
        logic       ok;
        fork
            capture_frame(cap, ok);
            reg_write(name, `UART_REG_TX, {24'h0, b}, 4'b0001);
        join
        check_true(name, ok, "frame shape or bit length wrong on txd");
        check_val(name, {24'h0, b}, {24'h0, cap});
    endtask

    // Second write is issued while the first frame is still going out
    task automatic send_pair(input string name, input logic [7:0] b0, input logic [7:0] b1);
        logic [7:0] cap0;
        logic [7:0] cap1;
        logic       ok0;
        logic       ok1;
        time        t_end0;
        time        t_ready1;
        fork
            begin
                capture_frame(cap0, ok0);
                t_end0 = $time;
                capture_frame(cap1, ok1);
            end
            begin
                reg_write(name, `UART_REG_TX, {24'h0, b0}, 4'b0001);
                reg_write(name, `UART_REG_TX, {24'h0, b1}, 4'b0001);
                t_ready1 = $time;
            end
        join
        check_true(name, t_ready1 > t_end0, "stalled write got ready before the stop bit ended");
        check_true(name, ok0 && ok1, "frame shape or bit length wrong on txd");
        check_val(name, {24'h0, b0}, {24'h0, cap0});
        check_val(name, {24'h0, b1}, {24'h0, cap1});
    endtask

    task automatic report_test(input string name, input int err_start);
        $display("%-10s %s (%0d errors)", name,
                 (errors == err_start) ? "PASS" : "FAIL", errors - err_start);
    endtask

    // --------------------
    // Watchdog
    // --------------------
    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("Timeout after %0d cycles, a wait never ended", TIMEOUT_CYC);
        $display("Checks failed");
        $finish;
    end

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        logic [7:0]  b0;
        logic [7:0]  b1;
        logic [31:0] rd;
        logic        got;
        int          n;
        int          err_start;

        rst         = 1'b1;
        req         = '0;
        loop_sel    = 1'b0;
        drv_line    = 1'b1;
        frame_phase = 1'b0;
        lfsr_state  = 32'h1803478e;
        checks      = 0;
        errors      = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Idle state out of reset
        err_start = errors;
        repeat (3) @(posedge clk);
        check_val("reset", 32'h1, {31'h0, txd});
        check_val("reset", 32'h0, {31'h0, irq_rx_valid});
        check_read("reset", `UART_REG_STATUS, status_word(1'b0, 1'b0));
        report_test("reset", err_start);

        // Random bytes at prescale 2, then a foreign base address
        err_start = errors;
        reg_write("transmit", `UART_REG_BAUD, PRESCALE, 4'b0011);
        for (n = 0; n < 4; n++) begin
            next_byte(b0);
            send_one("transmit", b0);
        end
        bus_access(32'h0500_0000, 32'h55, 4'b0001, BUS_WAIT, rd, got);
        check_true("transmit", !got, "write to a foreign base address got a ready");
        report_test("transmit", err_start);

        err_start = errors;
        next_byte(b0);
        next_byte(b1);
        send_pair("stall", b0, b1);
        report_test("stall", err_start);

        // Loopback through the receiver
        err_start = errors;
        @(posedge clk);
        loop_sel <= 1'b1;
        next_byte(b0);
        reg_write("loopback", `UART_REG_TX, {24'h0, b0}, 4'b0001);
        n = 0;
        while (!irq_rx_valid && n < STALL_WAIT) begin
            @(posedge clk);
            n++;
        end
        check_true("loopback", irq_rx_valid, "interrupt did not rise after a looped frame");
        check_read("loopback", `UART_REG_RX, {24'h0, b0});
        @(posedge clk);
        check_val("loopback", 32'h0, {31'h0, irq_rx_valid});
        check_read("loopback", `UART_REG_RX, 32'hFFFF_FF00);
        report_test("loopback", err_start);

        // Two unread bytes, the first one is kept
        err_start = errors;
        next_byte(b0);
        next_byte(b1);
        send_pair("overrun", b0, b1);
        check_read("overrun", `UART_REG_STATUS, status_word(1'b1, 1'b0));
        check_read("overrun", `UART_REG_RX, {24'h0, b0});
        check_read("overrun", `UART_REG_STATUS, status_word(1'b0, 1'b0));
        report_test("overrun", err_start);

        // Low stop bit from the driver
        err_start = errors;
        @(posedge clk);
        loop_sel    <= 1'b0;
        frame_phase <= 1'b1;
        next_byte(b0);
        drive_serial(b0, 1'b0);
        check_read("frame_err", `UART_REG_STATUS, status_word(1'b0, 1'b1));
        check_read("frame_err", `UART_REG_STATUS, status_word(1'b0, 1'b0));
        check_val("frame_err", 32'h0, {31'h0, irq_rx_valid});
        @(posedge clk);
        frame_phase <= 1'b0;
        report_test("frame_err", err_start);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+src
src/mem_bus_pkg.sv
src/uart_pkg.sv
src/uart_byte_if.sv
src/mem_bus_unpack.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_regs.sv
src/uart_mmio.sv
verif/uart_mmio_tb.sv
